//--- rtl/core_mem_pkg.sv
`default_nettype none

package core_mem_pkg;

    localparam int ADDR_W  = 64;
    localparam int DATA_W  = 64;
    localparam int STRB_W  = DATA_W / 8;
    localparam int INSTR_W = 32;

    localparam logic [ADDR_W-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // funct3 style access sizes, bit 2 of the size input is the unsigned flag
    localparam logic [2:0] SIZE_B = 3'd0;
    localparam logic [2:0] SIZE_H = 3'd1;
    localparam logic [2:0] SIZE_W = 3'd2;
    localparam logic [2:0] SIZE_D = 3'd3;

    localparam int   NUM_CLIENTS  = 2;
    localparam logic CLIENT_LSU   = 1'b0;   // wins when both request
    localparam logic CLIENT_FETCH = 1'b1;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none

module fetch_unit import core_mem_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 redirect_valid_i,
    input  wire  [ADDR_W-1:0]   redirect_pc_i,
    input  wire                 instr_ready_i,
    output logic                instr_valid_o,
    output logic [INSTR_W-1:0]  instr_o,
    output logic [ADDR_W-1:0]   instr_pc_o,
    output logic                bus_req_o,
    output logic [ADDR_W-1:0]   bus_addr_o,
    input  wire                 bus_done_i,
    input  wire  [DATA_W-1:0]   bus_rdata_i
);

    logic [ADDR_W-1:0] pc;
    logic              discard;     // read in flight belongs to the old path
    logic              launch;
    logic              fill;

    // only fetch when the buffer is empty or being drained this cycle
    assign launch = !bus_req_o && !redirect_valid_i && (!instr_valid_o || instr_ready_i);
    assign fill   = bus_done_i && !discard && !redirect_valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc            <= RESET_PC;
            instr_valid_o <= 1'b0;
            bus_req_o     <= 1'b0;
            discard       <= 1'b0;
        end else begin
            if (instr_valid_o && instr_ready_i) begin
                instr_valid_o <= 1'b0;
            end
            if (launch) begin
                bus_req_o <= 1'b1;
            end else if (bus_done_i) begin
                bus_req_o <= 1'b0;
                discard   <= 1'b0;
            end
            if (fill) begin
                instr_valid_o <= 1'b1;
                pc            <= pc + ADDR_W'(4);
            end
            if (redirect_valid_i) begin
                instr_valid_o <= 1'b0;
                pc            <= redirect_pc_i;
                discard       <= bus_req_o && !bus_done_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            bus_addr_o <= {pc[ADDR_W-1:3], 3'b000};     // bus is 8 bytes wide
        end
        if (fill) begin
            instr_o    <= pc[2] ? bus_rdata_i[DATA_W-1:INSTR_W] : bus_rdata_i[INSTR_W-1:0];
            instr_pc_o <= pc;
        end
    end

    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst)
        redirect_valid_i |-> redirect_pc_i[1:0] == 2'b00
    );

endmodule

`default_nettype wire

//--- rtl/load_store_unit.sv
`default_nettype none

module load_store_unit import core_mem_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 req_valid_i,
    input  wire                 req_write_i,
    input  wire  [ADDR_W-1:0]   req_addr_i,
    input  wire  [2:0]          req_size_i,
    input  wire  [DATA_W-1:0]   req_wdata_i,
    output logic                req_ready_o,
    output logic                resp_valid_o,
    output logic [DATA_W-1:0]   resp_rdata_o,
    output logic                bus_req_o,
    output logic                bus_write_o,
    output logic [ADDR_W-1:0]   bus_addr_o,
    output logic [DATA_W-1:0]   bus_wdata_o,
    output logic [STRB_W-1:0]   bus_strb_o,
    input  wire                 bus_done_i,
    input  wire  [DATA_W-1:0]   bus_rdata_i
);

    logic              busy;
    logic              accept;
    logic [2:0]        size_q;
    logic [2:0]        off_q;
    logic [STRB_W-1:0] base_strb;
    logic [2:0]        align_mask;
    logic              sext;
    logic [DATA_W-1:0] lane_data;
    logic [DATA_W-1:0] load_data;

    assign req_ready_o = !busy;
    assign accept      = req_valid_i && req_ready_o;
    assign sext        = !size_q[2];
    assign lane_data   = bus_rdata_i >> {off_q, 3'b000};    // addressed byte to lane 0

    always_comb begin
        case ({1'b0, req_size_i[1:0]})
            SIZE_B: begin
                base_strb  = STRB_W'(8'h01);
                align_mask = 3'b000;
            end
            SIZE_H: begin
                base_strb  = STRB_W'(8'h03);
                align_mask = 3'b001;
            end
            SIZE_W: begin
                base_strb  = STRB_W'(8'h0f);
                align_mask = 3'b011;
            end
            default: begin
                base_strb  = '1;
                align_mask = 3'b111;
            end
        endcase
    end

    always_comb begin
        case ({1'b0, size_q[1:0]})
            SIZE_B:  load_data = {{(DATA_W-8){sext & lane_data[7]}}, lane_data[7:0]};
            SIZE_H:  load_data = {{(DATA_W-16){sext & lane_data[15]}}, lane_data[15:0]};
            SIZE_W:  load_data = {{(DATA_W-32){sext & lane_data[31]}}, lane_data[31:0]};
            default: load_data = lane_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            bus_req_o    <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= bus_done_i;     // response trails done by one cycle
            if (accept) begin
                busy      <= 1'b1;
                bus_req_o <= 1'b1;
            end
            if (bus_done_i) begin
                bus_req_o <= 1'b0;
            end
            if (resp_valid_o) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus_write_o <= req_write_i;
            bus_addr_o  <= {req_addr_i[ADDR_W-1:3], 3'b000};
            bus_wdata_o <= req_wdata_i << {req_addr_i[2:0], 3'b000};
            bus_strb_o  <= base_strb << req_addr_i[2:0];
            size_q      <= req_size_i;
            off_q       <= req_addr_i[2:0];
        end
        if (bus_done_i) begin
            resp_rdata_o <= bus_write_o ? '0 : load_data;   // stores answer zero
        end
    end

    a_natural_align: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> (req_addr_i[2:0] & align_mask) == 3'b000
    );

endmodule

`default_nettype wire

//--- rtl/bus_arbiter.sv
`default_nettype none

module bus_arbiter import core_mem_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [NUM_CLIENTS-1:0]  cli_req_i,
    input  wire  [NUM_CLIENTS-1:0]  cli_write_i,
    input  wire  [ADDR_W-1:0]       cli_addr_i  [NUM_CLIENTS],
    input  wire  [DATA_W-1:0]       cli_wdata_i [NUM_CLIENTS],
    input  wire  [STRB_W-1:0]       cli_strb_i  [NUM_CLIENTS],
    output logic [NUM_CLIENTS-1:0]  cli_done_o,
    output logic [DATA_W-1:0]       cli_rdata_o,
    output logic                    bus_req_o,
    output logic                    bus_write_o,
    output logic [ADDR_W-1:0]       bus_addr_o,
    output logic [DATA_W-1:0]       bus_wdata_o,
    output logic [STRB_W-1:0]       bus_strb_o,
    input  wire                     bus_done_i,
    input  wire  [DATA_W-1:0]       bus_rdata_i
);

    logic locked;
    logic owner;
    logic sel;

    // fixed priority while free, owner while locked
    assign sel = locked ? owner : (cli_req_i[CLIENT_LSU] ? CLIENT_LSU : CLIENT_FETCH);

    assign bus_req_o   = cli_req_i[sel];
    assign bus_write_o = cli_write_i[sel];
    assign bus_addr_o  = cli_addr_i[sel];
    assign bus_wdata_o = cli_wdata_i[sel];
    assign bus_strb_o  = cli_strb_i[sel];
    assign cli_rdata_o = bus_rdata_i;   // shared, only the owner sees done

    always_comb begin
        cli_done_o        = '0;
        cli_done_o[owner] = bus_done_i && locked;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= CLIENT_LSU;
        end else if (!locked && bus_req_o) begin
            locked <= 1'b1;
            owner  <= sel;
        end else if (locked && bus_done_i) begin
            locked <= 1'b0;
        end
    end

    a_done_to_requester: assert property (
        @(posedge clk) disable iff (rst)
        (cli_done_o & ~cli_req_i) == '0
    );

    a_owner_req_held: assert property (
        @(posedge clk) disable iff (rst)
        locked |-> cli_req_i[owner]
    );

endmodule

`default_nettype wire

//--- rtl/axi_single_master.sv
`default_nettype none

module axi_single_master import core_mem_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 bus_req_i,
    input  wire                 bus_write_i,
    input  wire  [ADDR_W-1:0]   bus_addr_i,
    input  wire  [DATA_W-1:0]   bus_wdata_i,
    input  wire  [STRB_W-1:0]   bus_strb_i,
    output logic                bus_done_o,
    output logic [DATA_W-1:0]   bus_rdata_o,
    input  wire                 axi_awready_i,
    output logic                axi_awvalid_o,
    output logic [ADDR_W-1:0]   axi_awaddr_o,
    input  wire                 axi_wready_i,
    output logic                axi_wvalid_o,
    output logic [DATA_W-1:0]   axi_wdata_o,
    output logic [STRB_W-1:0]   axi_wstrb_o,
    output logic                axi_wlast_o,
    input  wire                 axi_bvalid_i,
    output logic                axi_bready_o,
    input  wire                 axi_arready_i,
    output logic                axi_arvalid_o,
    output logic [ADDR_W-1:0]   axi_araddr_o,
    input  wire                 axi_rvalid_i,
    input  wire  [DATA_W-1:0]   axi_rdata_i,
    input  wire                 axi_rlast_i,
    output logic                axi_rready_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP,
        ST_DONE
    } state_t;

    state_t state;
    logic   aw_end;
    logic   w_end;
    logic   addr_end;
    logic   resp_end;

    // aw and w finish independently, in either order
    assign aw_end   = !axi_awvalid_o || axi_awready_i;
    assign w_end    = !axi_wvalid_o || axi_wready_i;
    assign addr_end = bus_write_i ? (aw_end && w_end) : axi_arready_i;
    assign resp_end = bus_write_i ? axi_bvalid_i : axi_rvalid_i;

    assign axi_awaddr_o = bus_addr_i;   // client holds fields until done
    assign axi_araddr_o = bus_addr_i;
    assign axi_wdata_o  = bus_wdata_i;
    assign axi_wstrb_o  = bus_strb_i;
    assign axi_wlast_o  = axi_wvalid_o; // single beat
    assign axi_bready_o = (state == ST_RESP) && bus_write_i;
    assign axi_rready_o = (state == ST_RESP) && !bus_write_i;
    assign bus_done_o   = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            axi_awvalid_o <= 1'b0;
            axi_wvalid_o  <= 1'b0;
            axi_arvalid_o <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bus_req_i) begin
                        state         <= ST_ADDR;
                        axi_awvalid_o <= bus_write_i;
                        axi_wvalid_o  <= bus_write_i;
                        axi_arvalid_o <= !bus_write_i;
                    end
                end
                ST_ADDR: begin
                    if (axi_awready_i) begin
                        axi_awvalid_o <= 1'b0;
                    end
                    if (axi_wready_i) begin
                        axi_wvalid_o <= 1'b0;
                    end
                    if (axi_arready_i) begin
                        axi_arvalid_o <= 1'b0;
                    end
                    if (addr_end) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (resp_end) begin
                        state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (axi_rvalid_i && axi_rready_o) begin
            bus_rdata_o <= axi_rdata_i;
        end
    end

    a_aw_hold: assert property (
        @(posedge clk) disable iff (rst)
        axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o)
    );

    a_w_hold: assert property (
        @(posedge clk) disable iff (rst)
        axi_wvalid_o && !axi_wready_i |=>
            axi_wvalid_o && $stable(axi_wdata_o) && $stable(axi_wstrb_o)
    );

    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o)
    );

    a_rlast: assert property (
        @(posedge clk) disable iff (rst)
        axi_rvalid_i && axi_rready_o |-> axi_rlast_i
    );

endmodule

`default_nettype wire

//--- rtl/core_mem_top.sv
`default_nettype none

module core_mem_top import core_mem_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 redirect_valid_i,
    input  wire  [ADDR_W-1:0]   redirect_pc_i,
    output wire                 instr_valid_o,
    output wire  [INSTR_W-1:0]  instr_o,
    output wire  [ADDR_W-1:0]   instr_pc_o,
    input  wire                 instr_ready_i,
    input  wire                 req_valid_i,
    input  wire                 req_write_i,
    input  wire  [ADDR_W-1:0]   req_addr_i,
    input  wire  [2:0]          req_size_i,
    input  wire  [DATA_W-1:0]   req_wdata_i,
    output wire                 req_ready_o,
    output wire                 resp_valid_o,
    output wire  [DATA_W-1:0]   resp_rdata_o,
    input  wire                 axi_awready_i,
    output wire                 axi_awvalid_o,
    output wire  [ADDR_W-1:0]   axi_awaddr_o,
    input  wire                 axi_wready_i,
    output wire                 axi_wvalid_o,
    output wire  [DATA_W-1:0]   axi_wdata_o,
    output wire  [STRB_W-1:0]   axi_wstrb_o,
    output wire                 axi_wlast_o,
    input  wire                 axi_bvalid_i,
    output wire                 axi_bready_o,
    input  wire                 axi_arready_i,
    output wire                 axi_arvalid_o,
    output wire  [ADDR_W-1:0]   axi_araddr_o,
    input  wire                 axi_rvalid_i,
    input  wire  [DATA_W-1:0]   axi_rdata_i,
    input  wire                 axi_rlast_i,
    output wire                 axi_rready_o
);

    wire [NUM_CLIENTS-1:0] cli_req;
    wire [NUM_CLIENTS-1:0] cli_write;
    wire [NUM_CLIENTS-1:0] cli_done;
    wire [ADDR_W-1:0]      cli_addr  [NUM_CLIENTS];
    wire [DATA_W-1:0]      cli_wdata [NUM_CLIENTS];
    wire [STRB_W-1:0]      cli_strb  [NUM_CLIENTS];
    wire [DATA_W-1:0]      cli_rdata;

    wire                   bus_req;
    wire                   bus_write;
    wire [ADDR_W-1:0]      bus_addr;
    wire [DATA_W-1:0]      bus_wdata;
    wire [STRB_W-1:0]      bus_strb;
    wire                   bus_done;
    wire [DATA_W-1:0]      bus_rdata;

    // fetch never writes
    assign cli_write[CLIENT_FETCH] = 1'b0;
    assign cli_wdata[CLIENT_FETCH] = '0;
    assign cli_strb[CLIENT_FETCH]  = '0;

    fetch_unit u_fetch (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .instr_ready_i    (instr_ready_i),
        .instr_valid_o    (instr_valid_o),
        .instr_o          (instr_o),
        .instr_pc_o       (instr_pc_o),
        .bus_req_o        (cli_req[CLIENT_FETCH]),
        .bus_addr_o       (cli_addr[CLIENT_FETCH]),
        .bus_done_i       (cli_done[CLIENT_FETCH]),
        .bus_rdata_i      (cli_rdata)
    );

    load_store_unit u_lsu (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_size_i   (req_size_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .bus_req_o    (cli_req[CLIENT_LSU]),
        .bus_write_o  (cli_write[CLIENT_LSU]),
        .bus_addr_o   (cli_addr[CLIENT_LSU]),
        .bus_wdata_o  (cli_wdata[CLIENT_LSU]),
        .bus_strb_o   (cli_strb[CLIENT_LSU]),
        .bus_done_i   (cli_done[CLIENT_LSU]),
        .bus_rdata_i  (cli_rdata)
    );

    bus_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .cli_req_i   (cli_req),
        .cli_write_i (cli_write),
        .cli_addr_i  (cli_addr),
        .cli_wdata_i (cli_wdata),
        .cli_strb_i  (cli_strb),
        .cli_done_o  (cli_done),
        .cli_rdata_o (cli_rdata),
        .bus_req_o   (bus_req),
        .bus_write_o (bus_write),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_strb_o  (bus_strb),
        .bus_done_i  (bus_done),
        .bus_rdata_i (bus_rdata)
    );

    axi_single_master u_axi (
        .clk           (clk),
        .rst           (rst),
        .bus_req_i     (bus_req),
        .bus_write_i   (bus_write),
        .bus_addr_i    (bus_addr),
        .bus_wdata_i   (bus_wdata),
        .bus_strb_i    (bus_strb),
        .bus_done_o    (bus_done),
        .bus_rdata_o   (bus_rdata),
        .axi_awready_i (axi_awready_i),
        .axi_awvalid_o (axi_awvalid_o),
        .axi_awaddr_o  (axi_awaddr_o),
        .axi_wready_i  (axi_wready_i),
        .axi_wvalid_o  (axi_wvalid_o),
        .axi_wdata_o   (axi_wdata_o),
        .axi_wstrb_o   (axi_wstrb_o),
        .axi_wlast_o   (axi_wlast_o),
        .axi_bvalid_i  (axi_bvalid_i),
        .axi_bready_o  (axi_bready_o),
        .axi_arready_i (axi_arready_i),
        .axi_arvalid_o (axi_arvalid_o),
        .axi_araddr_o  (axi_araddr_o),
        .axi_rvalid_i  (axi_rvalid_i),
        .axi_rdata_i   (axi_rdata_i),
        .axi_rlast_i   (axi_rlast_i),
        .axi_rready_o  (axi_rready_o)
    );

endmodule

`default_nettype wire

//--- verification/tb_core_mem.sv
`default_nettype none

module tb_core_mem import core_mem_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int CYCLES_PER_LINE = 300;

    logic                clk;
    logic                rst;
    logic                redirect_valid_i;
    logic [ADDR_W-1:0]   redirect_pc_i;
    logic                instr_valid_o;
    logic [INSTR_W-1:0]  instr_o;
    logic [ADDR_W-1:0]   instr_pc_o;
    logic                instr_ready_i;
    logic                req_valid_i;
    logic                req_write_i;
    logic [ADDR_W-1:0]   req_addr_i;
    logic [2:0]          req_size_i;
    logic [DATA_W-1:0]   req_wdata_i;
    logic                req_ready_o;
    logic                resp_valid_o;
    logic [DATA_W-1:0]   resp_rdata_o;
    logic                axi_awready_i;
    logic                axi_awvalid_o;
    logic [ADDR_W-1:0]   axi_awaddr_o;
    logic                axi_wready_i;
    logic                axi_wvalid_o;
    logic [DATA_W-1:0]   axi_wdata_o;
    logic [STRB_W-1:0]   axi_wstrb_o;
    logic                axi_wlast_o;
    logic                axi_bvalid_i;
    logic                axi_bready_o;
    logic                axi_arready_i;
    logic                axi_arvalid_o;
    logic [ADDR_W-1:0]   axi_araddr_o;
    logic                axi_rvalid_i;
    logic [DATA_W-1:0]   axi_rdata_i;
    logic                axi_rlast_i;
    logic                axi_rready_o;

    logic [DATA_W-1:0]   mem [logic [ADDR_W-1:0]];     // 8-byte words, written ones only
    logic [7:0]          op_code   [$];
    logic [ADDR_W-1:0]   op_addr   [$];
    logic [2:0]          op_size   [$];
    logic [DATA_W-1:0]   op_wdata  [$];
    logic [DATA_W-1:0]   op_expect [$];
    logic [ADDR_W-1:0]   exp_pc;
    logic                loaded;
    int                  pending;                       // instructions still to consume
    int                  cur_op;
    int                  n_req;
    int                  n_resp;
    int                  n_checks;
    int                  n_err;

    core_mem_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic after_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expv);
        n_checks++;
        assert (got === expv) else begin
            n_err++;
            $display("mismatch %s: got %h expected %h", name, got, expv);
        end
    endtask

    // unwritten 32-bit word at a holds both address halves xor 32'h13579bdf
    function automatic logic [31:0] fill_word(input logic [ADDR_W-1:0] a);
        return a[63:32] ^ a[31:0] ^ 32'h13579bdf;
    endfunction

    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {fill_word(a + 64'd4), fill_word(a)};
    endfunction

    task automatic serve_write();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] word;
        int                i;
        fork
            begin
                repeat ($urandom_range(3, 0)) after_edge();
                addr          = axi_awaddr_o;
                axi_awready_i = 1'b1;
                after_edge();
                axi_awready_i = 1'b0;
            end
            begin
                repeat ($urandom_range(3, 0)) after_edge();
                data = axi_wdata_o;
                strb = axi_wstrb_o;
                check_value("axi_wlast_o", axi_wlast_o, 1'b1);
                axi_wready_i = 1'b1;
                after_edge();
                axi_wready_i = 1'b0;
            end
        join
        word = mem_word(addr);
        for (i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        mem[addr] = word;
        repeat ($urandom_range(3, 0)) after_edge();
        axi_bvalid_i = 1'b1;
        while (!axi_bready_o) after_edge();
        after_edge();
        axi_bvalid_i = 1'b0;
    endtask

    task automatic serve_read();
        logic [ADDR_W-1:0] addr;
        repeat ($urandom_range(3, 0)) after_edge();
        addr          = axi_araddr_o;
        axi_arready_i = 1'b1;
        after_edge();
        axi_arready_i = 1'b0;
        repeat ($urandom_range(3, 0)) after_edge();
        axi_rdata_i  = mem_word(addr);
        axi_rvalid_i = 1'b1;
        axi_rlast_i  = 1'b1;   // every read is one beat
        while (!axi_rready_o) after_edge();
        after_edge();
        axi_rvalid_i = 1'b0;
        axi_rlast_i  = 1'b0;
    endtask

    task automatic load_stimulus();
        int                fd;
        int                code;
        logic [7:0]        op;
        logic [ADDR_W-1:0] a;
        logic [2:0]        sz;
        logic [DATA_W-1:0] wd;
        logic [DATA_W-1:0] ev;
        logic [8*200-1:0]  rest;
        fd = $fopen("verification/core_mem_stimulus.txt", "r");
        if (fd == 0) begin
            n_err++;
            $display("could not open the stimulus file verification/core_mem_stimulus.txt");
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                if (op == "#") begin
                    code = $fgets(rest, fd);   // comment line
                end else begin
                    code = $fscanf(fd, "%h %h %h %h", a, sz, wd, ev);
                    if (code != 4) begin
                        n_err++;
                        $display("stimulus line for operation %c is malformed", op);
                    end
                    op_code.push_back(op);
                    op_addr.push_back(a);
                    op_size.push_back(sz);
                    op_wdata.push_back(wd);
                    op_expect.push_back(ev);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic pulse_redirect(input logic [ADDR_W-1:0] target);
        wait (pending == 0);   // consumer idle, ready held low
        after_edge();
        redirect_valid_i = 1'b1;
        redirect_pc_i    = target;
        exp_pc           = target;
        after_edge();
        redirect_valid_i = 1'b0;
    endtask

    task automatic mem_request(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [2:0] size, input logic [DATA_W-1:0] wdata,
                               input logic [DATA_W-1:0] expv);
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_size_i  = size;
        req_wdata_i = wdata;
        while (!req_ready_o) after_edge();
        after_edge();
        req_valid_i = 1'b0;
        n_req++;
        while (!resp_valid_o) after_edge();
        check_value("resp_rdata_o", resp_rdata_o, expv);
    endtask

    initial begin
        forever begin
            after_edge();
            if (axi_awvalid_o === 1'b1) begin
                serve_write();
            end else if (axi_arvalid_o === 1'b1) begin
                serve_read();
            end
        end
    end

    initial begin
        forever begin
            after_edge();
            instr_ready_i = (pending > 0) && ($urandom_range(3, 0) != 0);
            if (instr_ready_i && instr_valid_o === 1'b1) begin   // transfer at next edge
                check_value("instr_pc_o", instr_pc_o, exp_pc);
                check_value("instr_o", instr_o, fill_word(exp_pc));
                exp_pc = exp_pc + 64'd4;
                pending--;
            end
        end
    end

    initial begin
        forever begin
            after_edge();
            if (resp_valid_o === 1'b1) begin
                n_resp++;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (CYCLES_PER_LINE * op_code.size() + 20) @(posedge clk);
        $display("timeout: operation %0d (%c) did not complete within the time allowed",
                 cur_op, op_code[cur_op]);
        $display("checks %0d errors %0d", n_checks, n_err + 1);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h74f));
        rst              = 1'b1;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        instr_ready_i    = 1'b0;
        req_valid_i      = 1'b0;
        req_write_i      = 1'b0;
        req_addr_i       = '0;
        req_size_i       = '0;
        req_wdata_i      = '0;
        axi_awready_i    = 1'b0;
        axi_wready_i     = 1'b0;
        axi_bvalid_i     = 1'b0;
        axi_arready_i    = 1'b0;
        axi_rvalid_i     = 1'b0;
        axi_rdata_i      = '0;
        axi_rlast_i      = 1'b0;
        exp_pc           = RESET_PC;
        pending          = 0;
        cur_op           = 0;
        n_req            = 0;
        n_resp           = 0;
        n_checks         = 0;
        n_err            = 0;
        loaded           = 1'b0;

        load_stimulus();
        if (op_code.size() == 0) begin
            n_err++;
            $display("the stimulus file holds no operations");
        end else begin
            loaded = 1'b1;
        end

        repeat (4) @(posedge clk);
        #1;
        check_value("req_ready_o", req_ready_o, 1'b1);
        check_value("instr_valid_o", instr_valid_o, 1'b0);
        check_value("resp_valid_o", resp_valid_o, 1'b0);
        check_value("axi_awvalid_o", axi_awvalid_o, 1'b0);
        check_value("axi_wvalid_o", axi_wvalid_o, 1'b0);
        check_value("axi_arvalid_o", axi_arvalid_o, 1'b0);
        check_value("cli_req", dut.cli_req, 2'b00);
        rst = 1'b0;

        for (int idx = 0; idx < op_code.size(); idx++) begin
            cur_op = idx;
            case (op_code[idx])
                "F": pending += int'(op_addr[idx]);   // consumer runs alongside
                "R": pulse_redirect(op_addr[idx]);
                "S": mem_request(1'b1, op_addr[idx], op_size[idx], op_wdata[idx],
                                 op_expect[idx]);
                "L": mem_request(1'b0, op_addr[idx], op_size[idx], op_wdata[idx],
                                 op_expect[idx]);
                default: begin
                    n_err++;
                    $display("unknown operation %c in the stimulus file", op_code[idx]);
                end
            endcase
        end
        wait (pending == 0);
        repeat (2) after_edge();
        check_value("resp_valid_o count", n_resp, n_req);

        $display("checks %0d errors %0d", n_checks, n_err);
        if (n_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/core_mem_stimulus.txt
# op addr size wdata expected, all hex; F carries its instruction count in the addr column
# F consume instructions, R redirect fetch to addr, S store, L load; unused columns are 0
F 8 0 0 0
L 80002000 3 0 9357bbdb9357bbdf
L 80002000 0 0 ffffffffffffffdf
L 80002001 4 0 bb
L 80002002 0 0 57
L 80002004 1 0 ffffffffffffbbdb
L 80002006 5 0 9357
L 80002004 2 0 ffffffff9357bbdb
L 80002008 6 0 9357bbd7
R 80000100 0 0 0
F 6 0 0 0
S 80002013 0 11223344556677a5 0
L 80002010 3 0 9357bbcba557bbcf
S 8000201e 1 cafebeef 0
L 80002018 3 0 beefbbc39357bbc7
L 8000201e 1 0 ffffffffffffbeef
S 80002004 2 ffffffff0badf00d 0
L 80002000 3 0 0badf00d9357bbdf
L 80002004 2 0 000000000badf00d
R 80000044 0 0 0
F 10 0 0 0
S 80002008 3 0123456789abcdef 0
L 80002008 3 0 0123456789abcdef
L 8000200a 1 0 ffffffffffff89ab
L 8000200c 6 0 1234567
L 8000200f 0 0 1

//--- project.f
rtl/core_mem_pkg.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/bus_arbiter.sv
rtl/axi_single_master.sv
rtl/core_mem_top.sv
verification/tb_core_mem.sv
